//--- hdl/axi_burst_pkg.sv
// AXI burst definitions
// word and field widths plus burst types for leader, follower, memory and checker

package axi_burst_pkg;

	// one word per data beat, also the CSR word
	localparam int DATA_WIDTH = 32;

	// AXI address bus, word addressed
	localparam int ADDR_WIDTH = 32;

	// length field, beats = len + 1
	localparam int LEN_WIDTH = 8;
	localparam int MAX_BEATS = 2 ** LEN_WIDTH;

	// low bit of the AXI encoding, WRAP not supported
	typedef enum logic {
		BURST_FIXED = 1'b0,
		BURST_INCR  = 1'b1
	} burst_e;

endpackage

//--- hdl/csr_map_pkg.sv
// CSR map of the loopback block
// register byte addresses and control/status bit positions

package csr_map_pkg;

	localparam int CSR_AW = 32;

	typedef enum logic [CSR_AW-1:0] {
		REG_CTRL      = 'h00,
		REG_LENGTH    = 'h04,
		REG_ADDR      = 'h08,
		REG_PATTERN   = 'h0C,
		REG_STATUS    = 'h10,
		REG_OUT_FIRST = 'h14,
		REG_OUT_LAST  = 'h18,
		REG_IN_FIRST  = 'h1C,
		REG_IN_LAST   = 'h20
	} csr_addr_e;

	// control register
	localparam int CTRL_WR_START = 0;
	localparam int CTRL_RD_START = 1;
	localparam int CTRL_BURST    = 4;

	// status register
	localparam int STS_WR_DONE  = 0;
	localparam int STS_RD_DONE  = 1;
	localparam int STS_CHK_DONE = 2;
	localparam int STS_CHK_ERR  = 3;
	localparam int STS_BUSY     = 4;

endpackage

//--- hdl/aximm_csr.sv
// Loopback control and status registers
// CPU strobe port, burst settings, start pulses and sticky status
`timescale 1ns/1ps

module aximm_csr
	import axi_burst_pkg::*, csr_map_pkg::*;
(
	input  logic                  ms_wr_clk,
	input  logic                  i_arst_n,
	input  logic [CSR_AW-1:0]     i_wr_addr,
	input  logic [DATA_WIDTH-1:0] i_wrdata,
	input  logic                  i_wren,
	input  logic                  i_rden,
	input  logic                  i_wr_done,
	input  logic                  i_rd_done,
	input  logic                  i_busy,
	input  logic                  i_chk_done,
	input  logic                  i_chk_err,
	input  logic [DATA_WIDTH-1:0] i_out_first,
	input  logic [DATA_WIDTH-1:0] i_out_last,
	input  logic [DATA_WIDTH-1:0] i_in_first,
	input  logic [DATA_WIDTH-1:0] i_in_last,
	output logic [DATA_WIDTH-1:0] o_master_readdata,
	output logic                  o_master_readdatavalid,
	output logic                  o_wr_start,
	output logic                  o_rd_start,
	output burst_e                o_burst,
	output logic [LEN_WIDTH-1:0]  o_length,
	output logic [ADDR_WIDTH-1:0] o_addr,
	output logic [DATA_WIDTH-1:0] o_pattern
);

	logic                  wr_done_q;
	logic                  rd_done_q;
	logic                  chk_done_q;
	logic                  chk_err_q;
	logic                  ctrl_wr;
	logic [DATA_WIDTH-1:0] status;
	logic [DATA_WIDTH-1:0] rd_mux;

	assign ctrl_wr = i_wren && (csr_addr_e'(i_wr_addr) == REG_CTRL);

	always_comb begin
		status = '0;
		status[STS_WR_DONE]  = wr_done_q;
		status[STS_RD_DONE]  = rd_done_q;
		status[STS_CHK_DONE] = chk_done_q;
		status[STS_CHK_ERR]  = chk_err_q;
		status[STS_BUSY]     = i_busy;
	end

	always_comb begin
		rd_mux = '0;
		case (csr_addr_e'(i_wr_addr))
			REG_CTRL:      rd_mux[CTRL_BURST] = o_burst;
			REG_LENGTH:    rd_mux = DATA_WIDTH'(o_length);
			REG_ADDR:      rd_mux = DATA_WIDTH'(o_addr);
			REG_PATTERN:   rd_mux = o_pattern;
			REG_STATUS:    rd_mux = status;
			REG_OUT_FIRST: rd_mux = i_out_first;
			REG_OUT_LAST:  rd_mux = i_out_last;
			REG_IN_FIRST:  rd_mux = i_in_first;
			REG_IN_LAST:   rd_mux = i_in_last;
			default:       rd_mux = '0;
		endcase
	end

	always_ff @(posedge ms_wr_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_burst                <= BURST_FIXED;
			o_length               <= '0;
			o_addr                 <= '0;
			o_pattern              <= '0;
			o_wr_start             <= 1'b0;
			o_rd_start             <= 1'b0;
			wr_done_q              <= 1'b0;
			rd_done_q              <= 1'b0;
			chk_done_q             <= 1'b0;
			chk_err_q              <= 1'b0;
			o_master_readdata      <= '0;
			o_master_readdatavalid <= 1'b0;
		end else begin
			// starts while busy are dropped here
			o_wr_start <= ctrl_wr && i_wrdata[CTRL_WR_START] && !i_busy;
			o_rd_start <= ctrl_wr && i_wrdata[CTRL_RD_START] && !i_busy;
			if (i_wren) begin
				case (csr_addr_e'(i_wr_addr))
					REG_CTRL:    o_burst <= burst_e'(i_wrdata[CTRL_BURST]);
					REG_LENGTH:  o_length <= i_wrdata[LEN_WIDTH-1:0];
					REG_ADDR:    o_addr <= ADDR_WIDTH'(i_wrdata);
					REG_PATTERN: o_pattern <= i_wrdata;
					default:     ;
				endcase
			end

			////////////////////
			// sticky status
			if (o_wr_start) begin
				wr_done_q  <= 1'b0;
				rd_done_q  <= 1'b0;
				chk_done_q <= 1'b0;
				chk_err_q  <= 1'b0;
			end else if (o_rd_start) begin
				rd_done_q  <= 1'b0;
				chk_done_q <= 1'b0;
			end else begin
				wr_done_q  <= wr_done_q | i_wr_done;
				rd_done_q  <= rd_done_q | i_rd_done;
				chk_done_q <= chk_done_q | i_chk_done;
				chk_err_q  <= chk_err_q | i_chk_err;
			end

			o_master_readdatavalid <= i_rden;
			if (i_rden)
				o_master_readdata <= rd_mux;
		end
	end

	// CPU never issues a read and a write together
	a_no_rw_overlap: assert property (@(posedge ms_wr_clk) disable iff (!i_arst_n)
		!(i_wren && i_rden));

endmodule

//--- hdl/aximm_leader_app.sv
// AXI burst leader
// issues one write or read burst per start, generates the write pattern
// and feeds each written word to the checker
`timescale 1ns/1ps

module aximm_leader_app
	import axi_burst_pkg::*;
#(
	parameter int MEM_AW = 8
) (
	input  logic                  ms_wr_clk,
	input  logic                  i_arst_n,
	input  logic                  i_wr_start,
	input  logic                  i_rd_start,
	input  burst_e                i_burst,
	input  logic [LEN_WIDTH-1:0]  i_length,
	input  logic [ADDR_WIDTH-1:0] i_addr,
	input  logic [DATA_WIDTH-1:0] i_pattern,
	output logic [ADDR_WIDTH-1:0] o_awaddr,
	output logic [LEN_WIDTH-1:0]  o_awlen,
	output burst_e                o_awburst,
	output logic                  o_awvalid,
	input  logic                  i_awready,
	output logic [DATA_WIDTH-1:0] o_wdata,
	output logic                  o_wlast,
	output logic                  o_wvalid,
	input  logic                  i_wready,
	input  logic                  i_bvalid,
	output logic                  o_bready,
	output logic [ADDR_WIDTH-1:0] o_araddr,
	output logic [LEN_WIDTH-1:0]  o_arlen,
	output burst_e                o_arburst,
	output logic                  o_arvalid,
	input  logic                  i_arready,
	input  logic [DATA_WIDTH-1:0] i_rdata,
	input  logic                  i_rlast,
	input  logic                  i_rvalid,
	output logic                  o_rready,
	output logic [DATA_WIDTH-1:0] o_exp_word,
	output logic                  o_exp_wr,
	output logic                  o_wr_done,
	output logic                  o_rd_done,
	output logic                  o_busy,
	output logic [DATA_WIDTH-1:0] o_out_first,
	output logic [DATA_WIDTH-1:0] o_out_last
);

	typedef enum logic [2:0] {ST_IDLE, ST_AW, ST_W, ST_B, ST_AR, ST_R} state_e;

	state_e               state;
	logic [LEN_WIDTH-1:0] beat;

	assign o_busy     = (state != ST_IDLE);
	assign o_bready   = 1'b1;
	assign o_rready   = 1'b1;
	assign o_wlast    = (beat == o_awlen);
	assign o_exp_wr   = o_wvalid && i_wready;
	assign o_exp_word = o_wdata;

	always_ff @(posedge ms_wr_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= ST_IDLE;
			beat      <= '0;
			o_awvalid <= 1'b0;
			o_wvalid  <= 1'b0;
			o_arvalid <= 1'b0;
			o_wr_done <= 1'b0;
			o_rd_done <= 1'b0;
		end else begin
			o_wr_done <= 1'b0;
			o_rd_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					// write wins if both starts arrive together
					if (i_wr_start) begin
						o_awvalid <= 1'b1;
						state     <= ST_AW;
					end else if (i_rd_start) begin
						o_arvalid <= 1'b1;
						state     <= ST_AR;
					end
				end
				ST_AW: if (i_awready) begin
					o_awvalid <= 1'b0;
					o_wvalid  <= 1'b1;
					beat      <= '0;
					state     <= ST_W;
				end
				ST_W: if (o_exp_wr) begin
					beat <= beat + 1'b1;
					if (o_wlast) begin
						o_wvalid <= 1'b0;
						state    <= ST_B;
					end
				end
				ST_B: if (i_bvalid) begin
					o_wr_done <= 1'b1;
					state     <= ST_IDLE;
				end
				ST_AR: if (i_arready) begin
					o_arvalid <= 1'b0;
					state     <= ST_R;
				end
				ST_R: if (i_rvalid && i_rlast) begin
					o_rd_done <= 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////
	// burst payload

	always_ff @(posedge ms_wr_clk) begin
		// start address folded into the follower memory window
		if (state == ST_IDLE && i_wr_start) begin
			o_awaddr  <= ADDR_WIDTH'(i_addr[MEM_AW-1:0]);
			o_awlen   <= i_length;
			o_awburst <= i_burst;
			o_wdata   <= i_pattern;
		end
		if (state == ST_IDLE && i_rd_start) begin
			o_araddr  <= ADDR_WIDTH'(i_addr[MEM_AW-1:0]);
			o_arlen   <= i_length;
			o_arburst <= i_burst;
		end
		// beat k carries pattern + k
		if (o_exp_wr) begin
			o_wdata <= o_wdata + 1'b1;
			if (beat == '0)
				o_out_first <= o_wdata;
			if (o_wlast)
				o_out_last <= o_wdata;
		end
	end

	a_aw_hold: assert property (@(posedge ms_wr_clk) disable iff (!i_arst_n)
		o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));

	// memory returns written words only
	a_rdata_known: assert property (@(posedge ms_wr_clk) disable iff (!i_arst_n)
		i_rvalid && o_rready |-> !$isunknown(i_rdata));

endmodule

//--- hdl/aximm_follower_app.sv
// AXI burst follower
// turns write and read bursts into local memory accesses, one beat per cycle
`timescale 1ns/1ps

module aximm_follower_app
	import axi_burst_pkg::*;
#(
	parameter int MEM_AW = 8
) (
	input  logic                  ms_wr_clk,
	input  logic                  i_arst_n,
	input  logic [ADDR_WIDTH-1:0] i_awaddr,
	input  logic [LEN_WIDTH-1:0]  i_awlen,
	input  burst_e                i_awburst,
	input  logic                  i_awvalid,
	output logic                  o_awready,
	input  logic [DATA_WIDTH-1:0] i_wdata,
	input  logic                  i_wlast,
	input  logic                  i_wvalid,
	output logic                  o_wready,
	output logic                  o_bvalid,
	input  logic                  i_bready,
	input  logic [ADDR_WIDTH-1:0] i_araddr,
	input  logic [LEN_WIDTH-1:0]  i_arlen,
	input  burst_e                i_arburst,
	input  logic                  i_arvalid,
	output logic                  o_arready,
	output logic [DATA_WIDTH-1:0] o_rdata,
	output logic                  o_rlast,
	output logic                  o_rvalid,
	input  logic                  i_rready,
	output logic [MEM_AW-1:0]     o_mem_wr_addr,
	output logic [DATA_WIDTH-1:0] o_mem_wr_data,
	output logic                  o_mem_wr_en,
	output logic [MEM_AW-1:0]     o_mem_rd_addr,
	input  logic [DATA_WIDTH-1:0] i_mem_rd_data,
	output logic [DATA_WIDTH-1:0] o_in_first,
	output logic [DATA_WIDTH-1:0] o_in_last
);

	typedef enum logic [1:0] {ST_IDLE, ST_WDATA, ST_WRESP, ST_RDATA} state_e;

	state_e               state;
	logic [MEM_AW-1:0]    addr;
	logic [MEM_AW-1:0]    next_addr;
	logic [LEN_WIDTH-1:0] len;
	logic [LEN_WIDTH-1:0] beat;
	burst_e               burst;

	// write channel has priority in idle
	assign o_awready = (state == ST_IDLE);
	assign o_arready = (state == ST_IDLE) && !i_awvalid;
	assign o_wready  = (state == ST_WDATA);
	assign o_bvalid  = (state == ST_WRESP);

	assign next_addr     = (burst == BURST_INCR) ? addr + 1'b1 : addr;
	assign o_mem_wr_en   = i_wvalid && o_wready;
	assign o_mem_wr_addr = addr;
	assign o_mem_wr_data = i_wdata;

	// look ahead one word on an accepted beat, else hold the current one
	assign o_mem_rd_addr = (o_rvalid && i_rready) ? next_addr : addr;
	assign o_rdata       = i_mem_rd_data;
	assign o_rlast       = o_rvalid && (beat == len);

	always_ff @(posedge ms_wr_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state    <= ST_IDLE;
			beat     <= '0;
			o_rvalid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					beat <= '0;
					if (i_awvalid)
						state <= ST_WDATA;
					else if (i_arvalid)
						state <= ST_RDATA;
				end
				ST_WDATA: if (o_mem_wr_en) begin
					beat <= beat + 1'b1;
					if (i_wlast)
						state <= ST_WRESP;
				end
				ST_WRESP: if (i_bready)
					state <= ST_IDLE;
				ST_RDATA: begin
					// first cycle covers the memory read latency
					o_rvalid <= 1'b1;
					if (o_rvalid && i_rready) begin
						beat <= beat + 1'b1;
						if (beat == len) begin
							o_rvalid <= 1'b0;
							state    <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge ms_wr_clk) begin
		if (state == ST_IDLE) begin
			if (i_awvalid) begin
				addr  <= i_awaddr[MEM_AW-1:0];
				len   <= i_awlen;
				burst <= i_awburst;
			end else if (i_arvalid) begin
				addr  <= i_araddr[MEM_AW-1:0];
				len   <= i_arlen;
				burst <= i_arburst;
			end
		end else if (o_mem_wr_en || (o_rvalid && i_rready)) begin
			addr <= next_addr;
		end
		if (o_mem_wr_en && beat == '0)
			o_in_first <= i_wdata;
		if (o_mem_wr_en && i_wlast)
			o_in_last <= i_wdata;
	end

	// leader wlast must agree with the awlen count
	a_wlast_count: assert property (@(posedge ms_wr_clk) disable iff (!i_arst_n)
		o_mem_wr_en |-> (i_wlast == (beat == len)));

endmodule

//--- hdl/burst_mem.sv
// Follower local memory
// one write port, one read port with a registered read
`timescale 1ns/1ps

module burst_mem
	import axi_burst_pkg::*;
#(
	parameter int MEM_AW = 8
) (
	input  logic                  ms_wr_clk,
	input  logic                  i_wr_en,
	input  logic [MEM_AW-1:0]     i_wr_addr,
	input  logic [DATA_WIDTH-1:0] i_wr_data,
	input  logic [MEM_AW-1:0]     i_rd_addr,
	output logic [DATA_WIDTH-1:0] o_rd_data
);

	logic [DATA_WIDTH-1:0] mem [2**MEM_AW];

	always_ff @(posedge ms_wr_clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

//--- hdl/aximm_patchkr.sv
// Read data checker
// queues the written words and compares them in order with the R beats
`timescale 1ns/1ps

module aximm_patchkr
	import axi_burst_pkg::*;
(
	input  logic                  ms_wr_clk,
	input  logic                  i_arst_n,
	input  logic                  i_clear,
	input  logic [DATA_WIDTH-1:0] i_exp_word,
	input  logic                  i_exp_wr,
	input  logic                  i_rvalid,
	input  logic                  i_rready,
	input  logic [DATA_WIDTH-1:0] i_rdata,
	input  logic                  i_rlast,
	output logic                  o_chk_done,
	output logic                  o_chk_err
);

	logic [DATA_WIDTH-1:0] fifo [MAX_BEATS];
	logic [LEN_WIDTH-1:0]  wr_ptr;
	logic [LEN_WIDTH-1:0]  rd_ptr;
	logic [LEN_WIDTH:0]    count;
	logic                  pop;

	assign pop = i_rvalid && i_rready;

	always_ff @(posedge ms_wr_clk) begin
		if (i_exp_wr)
			fifo[wr_ptr] <= i_exp_word;
	end

	always_ff @(posedge ms_wr_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_chk_done <= 1'b0;
			o_chk_err  <= 1'b0;
		end else begin
			o_chk_done <= pop && i_rlast;
			if (i_clear) begin
				wr_ptr    <= '0;
				rd_ptr    <= '0;
				count     <= '0;
				o_chk_err <= 1'b0;
			end else begin
				if (i_exp_wr)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop) begin
					rd_ptr <= rd_ptr + 1'b1;
					if (fifo[rd_ptr] != i_rdata)
						o_chk_err <= 1'b1;
				end
				count <= count + (LEN_WIDTH+1)'(i_exp_wr) - (LEN_WIDTH+1)'(pop);
			end
		end
	end

	// each read beat needs a word written before it
	a_no_empty_pop: assert property (@(posedge ms_wr_clk) disable iff (!i_arst_n)
		pop |-> count != '0);

endmodule

//--- hdl/aximm_loopback_top.sv
// AXI-MM loopback top
// CSR block, burst leader, follower with its memory, and read checker
`timescale 1ns/1ps

module aximm_loopback_top
	import axi_burst_pkg::*, csr_map_pkg::*;
#(
	parameter int MEM_AW = 8
) (
	input  logic                  ms_wr_clk,
	input  logic                  i_arst_n,
	input  logic [CSR_AW-1:0]     i_wr_addr,
	input  logic [DATA_WIDTH-1:0] i_wrdata,
	input  logic                  i_wren,
	input  logic                  i_rden,
	output logic [DATA_WIDTH-1:0] o_master_readdata,
	output logic                  o_master_readdatavalid
);

	// settings and status
	logic                  wr_start, rd_start, wr_done, rd_done, busy;
	logic                  chk_done, chk_err;
	burst_e                burst;
	logic [LEN_WIDTH-1:0]  length;
	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] pattern;
	logic [DATA_WIDTH-1:0] out_first, out_last, in_first, in_last;

	////////////////////
	// AXI channels
	logic [ADDR_WIDTH-1:0] awaddr, araddr;
	logic [LEN_WIDTH-1:0]  awlen, arlen;
	burst_e                awburst, arburst;
	logic                  awvalid, awready, arvalid, arready;
	logic [DATA_WIDTH-1:0] wdata, rdata;
	logic                  wlast, wvalid, wready, bvalid, bready;
	logic                  rlast, rvalid, rready;

	// checker feed and memory port
	logic [DATA_WIDTH-1:0] exp_word;
	logic                  exp_wr;
	logic [MEM_AW-1:0]     mem_wr_addr, mem_rd_addr;
	logic [DATA_WIDTH-1:0] mem_wr_data, mem_rd_data;
	logic                  mem_wr_en;

	aximm_csr u_csr (
		.ms_wr_clk              (ms_wr_clk),
		.i_arst_n               (i_arst_n),
		.i_wr_addr              (i_wr_addr),
		.i_wrdata               (i_wrdata),
		.i_wren                 (i_wren),
		.i_rden                 (i_rden),
		.i_wr_done              (wr_done),
		.i_rd_done              (rd_done),
		.i_busy                 (busy),
		.i_chk_done             (chk_done),
		.i_chk_err              (chk_err),
		.i_out_first            (out_first),
		.i_out_last             (out_last),
		.i_in_first             (in_first),
		.i_in_last              (in_last),
		.o_master_readdata      (o_master_readdata),
		.o_master_readdatavalid (o_master_readdatavalid),
		.o_wr_start             (wr_start),
		.o_rd_start             (rd_start),
		.o_burst                (burst),
		.o_length               (length),
		.o_addr                 (addr),
		.o_pattern              (pattern)
	);

	aximm_leader_app #(.MEM_AW(MEM_AW)) u_leader (
		.ms_wr_clk   (ms_wr_clk),
		.i_arst_n    (i_arst_n),
		.i_wr_start  (wr_start),
		.i_rd_start  (rd_start),
		.i_burst     (burst),
		.i_length    (length),
		.i_addr      (addr),
		.i_pattern   (pattern),
		.o_awaddr    (awaddr),
		.o_awlen     (awlen),
		.o_awburst   (awburst),
		.o_awvalid   (awvalid),
		.i_awready   (awready),
		.o_wdata     (wdata),
		.o_wlast     (wlast),
		.o_wvalid    (wvalid),
		.i_wready    (wready),
		.i_bvalid    (bvalid),
		.o_bready    (bready),
		.o_araddr    (araddr),
		.o_arlen     (arlen),
		.o_arburst   (arburst),
		.o_arvalid   (arvalid),
		.i_arready   (arready),
		.i_rdata     (rdata),
		.i_rlast     (rlast),
		.i_rvalid    (rvalid),
		.o_rready    (rready),
		.o_exp_word  (exp_word),
		.o_exp_wr    (exp_wr),
		.o_wr_done   (wr_done),
		.o_rd_done   (rd_done),
		.o_busy      (busy),
		.o_out_first (out_first),
		.o_out_last  (out_last)
	);

	aximm_follower_app #(.MEM_AW(MEM_AW)) u_follower (
		.ms_wr_clk     (ms_wr_clk),
		.i_arst_n      (i_arst_n),
		.i_awaddr      (awaddr),
		.i_awlen       (awlen),
		.i_awburst     (awburst),
		.i_awvalid     (awvalid),
		.o_awready     (awready),
		.i_wdata       (wdata),
		.i_wlast       (wlast),
		.i_wvalid      (wvalid),
		.o_wready      (wready),
		.o_bvalid      (bvalid),
		.i_bready      (bready),
		.i_araddr      (araddr),
		.i_arlen       (arlen),
		.i_arburst     (arburst),
		.i_arvalid     (arvalid),
		.o_arready     (arready),
		.o_rdata       (rdata),
		.o_rlast       (rlast),
		.o_rvalid      (rvalid),
		.i_rready      (rready),
		.o_mem_wr_addr (mem_wr_addr),
		.o_mem_wr_data (mem_wr_data),
		.o_mem_wr_en   (mem_wr_en),
		.o_mem_rd_addr (mem_rd_addr),
		.i_mem_rd_data (mem_rd_data),
		.o_in_first    (in_first),
		.o_in_last     (in_last)
	);

	burst_mem #(.MEM_AW(MEM_AW)) u_mem (
		.ms_wr_clk (ms_wr_clk),
		.i_wr_en   (mem_wr_en),
		.i_wr_addr (mem_wr_addr),
		.i_wr_data (mem_wr_data),
		.i_rd_addr (mem_rd_addr),
		.o_rd_data (mem_rd_data)
	);

	// expected queue restarts with every write burst
	aximm_patchkr u_patchkr (
		.ms_wr_clk  (ms_wr_clk),
		.i_arst_n   (i_arst_n),
		.i_clear    (wr_start),
		.i_exp_word (exp_word),
		.i_exp_wr   (exp_wr),
		.i_rvalid   (rvalid),
		.i_rready   (rready),
		.i_rdata    (rdata),
		.i_rlast    (rlast),
		.o_chk_done (chk_done),
		.o_chk_err  (chk_err)
	);

endmodule

//--- verif/tb_aximm_loopback_top.sv
// AXI-MM loopback testbench
// drives bursts through the CSR port and checks status and snapshots
// against a word model of the follower memory and the read checker
`timescale 1ns/1ps

module tb_aximm_loopback_top
	import axi_burst_pkg::*, csr_map_pkg::*;
;

	localparam int MEM_AW          = 8;
	localparam int MEM_SIZE        = 2 ** MEM_AW;
	localparam int CLK_PERIOD      = 40;
	localparam int NUM_PAIRS       = 5;
	// fixed scenarios use eleven bursts, each random pair two more
	localparam int NUM_BURSTS      = 11 + 2 * NUM_PAIRS;
	localparam int POLL_LIMIT      = MAX_BEATS + 16;
	localparam int WATCHDOG_CYCLES = NUM_BURSTS * (2 * MAX_BEATS + 64) + 500;

	logic                  ms_wr_clk = 1'b0;
	logic                  i_arst_n;
	logic [CSR_AW-1:0]     i_wr_addr;
	logic [DATA_WIDTH-1:0] i_wrdata;
	logic                  i_wren;
	logic                  i_rden;
	logic [DATA_WIDTH-1:0] o_master_readdata;
	logic                  o_master_readdatavalid;

	logic                  rden_q = 1'b0;
	logic [15:0]           lfsr = 16'd37063;

	// outstanding CPU reads, in issue order
	bit                    chk_q [$];
	logic [DATA_WIDTH-1:0] exp_q [$];
	string                 name_q [$];

	// reference model state
	logic [DATA_WIDTH-1:0] model_mem [MEM_SIZE];
	logic [DATA_WIDTH-1:0] model_exp [$];
	logic [DATA_WIDTH-1:0] exp_first;
	logic [DATA_WIDTH-1:0] exp_last;
	bit                    m_wr_done;
	bit                    m_rd_done;
	bit                    m_chk_done;
	bit                    m_err;

	aximm_loopback_top #(.MEM_AW(MEM_AW)) i_aximm_loopback_top (
		.ms_wr_clk              (ms_wr_clk),
		.i_arst_n               (i_arst_n),
		.i_wr_addr              (i_wr_addr),
		.i_wrdata               (i_wrdata),
		.i_wren                 (i_wren),
		.i_rden                 (i_rden),
		.o_master_readdata      (o_master_readdata),
		.o_master_readdatavalid (o_master_readdatavalid)
	);

	always #(CLK_PERIOD / 2) ms_wr_clk = ~ms_wr_clk;

	////////////////////
	// random source

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	////////////////////
	// reference model

	function automatic logic [MEM_AW-1:0] beat_addr(input logic [DATA_WIDTH-1:0] start,
		input burst_e burst, input int k);
		logic [MEM_AW-1:0] a;
		a = start[MEM_AW-1:0];
		if (burst == BURST_INCR)
			a = a + MEM_AW'(k);
		return a;
	endfunction

	function automatic void model_write(input logic [DATA_WIDTH-1:0] addr,
		input logic [LEN_WIDTH-1:0] len, input burst_e burst,
		input logic [DATA_WIDTH-1:0] pattern);
		int k;
		model_exp.delete();
		for (k = 0; k <= int'(len); k++) begin
			model_mem[beat_addr(addr, burst, k)] = pattern + DATA_WIDTH'(k);
			model_exp.push_back(pattern + DATA_WIDTH'(k));
		end
		exp_first  = pattern;
		exp_last   = pattern + DATA_WIDTH'(len);
		m_wr_done  = 1'b1;
		m_rd_done  = 1'b0;
		m_chk_done = 1'b0;
		m_err      = 1'b0;
	endfunction

	// read words are compared in order with the words of the last write
	function automatic void model_read(input logic [DATA_WIDTH-1:0] addr,
		input logic [LEN_WIDTH-1:0] len, input burst_e burst);
		logic [DATA_WIDTH-1:0] word;
		int k;
		for (k = 0; k <= int'(len); k++) begin
			word = model_mem[beat_addr(addr, burst, k)];
			if (model_exp.pop_front() != word)
				m_err = 1'b1;
		end
		m_rd_done  = 1'b1;
		m_chk_done = 1'b1;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] model_status();
		logic [DATA_WIDTH-1:0] s;
		s = '0;
		s[STS_WR_DONE]  = m_wr_done;
		s[STS_RD_DONE]  = m_rd_done;
		s[STS_CHK_DONE] = m_chk_done;
		s[STS_CHK_ERR]  = m_err;
		return s;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] ctrl_word(input burst_e burst,
		input bit wr, input bit rd);
		logic [DATA_WIDTH-1:0] w;
		w = '0;
		w[CTRL_BURST]    = burst;
		w[CTRL_WR_START] = wr;
		w[CTRL_RD_START] = rd;
		return w;
	endfunction

	////////////////////
	// checks

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] exp,
		input logic [DATA_WIDTH-1:0] act);
		if (act !== exp)
			fail_run($sformatf("Mismatch at %0t: %s expected 0x%08h actual 0x%08h",
				$time, name, exp, act));
	endtask

	always @(posedge ms_wr_clk)
		rden_q <= i_rden;

	// read data must follow i_rden by exactly one cycle
	always @(negedge ms_wr_clk) begin
		if (i_arst_n) begin
			check_value("o_master_readdatavalid", DATA_WIDTH'(rden_q),
				DATA_WIDTH'(o_master_readdatavalid));
			if (o_master_readdatavalid) begin
				if (chk_q.size() == 0)
					fail_run("read data returned with no CPU read outstanding");
				else if (chk_q.pop_front())
					check_value(name_q.pop_front(), exp_q.pop_front(), o_master_readdata);
				else begin
					void'(name_q.pop_front());
					void'(exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_run("watchdog expired before the test sequence finished");
	end

	////////////////////
	// CPU access, called on a falling edge

	task automatic cpu_write(input csr_addr_e addr, input logic [DATA_WIDTH-1:0] data);
		i_wr_addr = addr;
		i_wrdata  = data;
		i_wren    = 1'b1;
		@(negedge ms_wr_clk);
		i_wren = 1'b0;
		// lets a start clear the status before the next read
		@(negedge ms_wr_clk);
	endtask

	task automatic cpu_read(input csr_addr_e addr, input bit chk,
		input logic [DATA_WIDTH-1:0] exp, input string name,
		output logic [DATA_WIDTH-1:0] data);
		chk_q.push_back(chk);
		exp_q.push_back(exp);
		name_q.push_back(name);
		i_wr_addr = addr;
		i_rden    = 1'b1;
		@(negedge ms_wr_clk);
		i_rden = 1'b0;
		data   = o_master_readdata;
	endtask

	task automatic read_expect(input csr_addr_e addr, input logic [DATA_WIDTH-1:0] exp,
		input string name);
		logic [DATA_WIDTH-1:0] unused;
		cpu_read(addr, 1'b1, exp, name, unused);
	endtask

	task automatic wait_status(input int bit_pos, input string what);
		logic [DATA_WIDTH-1:0] data;
		int polls;
		bit seen;
		seen  = 1'b0;
		polls = 0;
		while (!seen && polls < POLL_LIMIT) begin
			cpu_read(REG_STATUS, 1'b0, '0, "status", data);
			seen = data[bit_pos];
			polls++;
		end
		if (!seen)
			fail_run($sformatf("the %s bit never set in the status register", what));
	endtask

	task automatic check_regs();
		read_expect(REG_STATUS, model_status(), "status");
		read_expect(REG_OUT_FIRST, exp_first, "out_first");
		read_expect(REG_OUT_LAST, exp_last, "out_last");
		read_expect(REG_IN_FIRST, exp_first, "in_first");
		read_expect(REG_IN_LAST, exp_last, "in_last");
	endtask

	////////////////////
	// bursts

	task automatic run_write(input logic [DATA_WIDTH-1:0] addr,
		input logic [LEN_WIDTH-1:0] len, input burst_e burst,
		input logic [DATA_WIDTH-1:0] pattern);
		cpu_write(REG_LENGTH, DATA_WIDTH'(len));
		cpu_write(REG_ADDR, addr);
		cpu_write(REG_PATTERN, pattern);
		cpu_write(REG_CTRL, ctrl_word(burst, 1'b1, 1'b0));
		wait_status(STS_WR_DONE, "write done");
		model_write(addr, len, burst, pattern);
	endtask

	task automatic run_read(input logic [DATA_WIDTH-1:0] addr,
		input logic [LEN_WIDTH-1:0] len, input burst_e burst);
		cpu_write(REG_LENGTH, DATA_WIDTH'(len));
		cpu_write(REG_ADDR, addr);
		cpu_write(REG_CTRL, ctrl_word(burst, 1'b0, 1'b1));
		wait_status(STS_RD_DONE, "read done");
		model_read(addr, len, burst);
	endtask

	task automatic random_pair(input bit force_incr);
		logic [DATA_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] pattern;
		logic [LEN_WIDTH-1:0]  len;
		burst_e                burst;
		addr    = take_bits(MEM_AW + 4);
		len     = LEN_WIDTH'(take_bits(LEN_WIDTH));
		pattern = take_bits(DATA_WIDTH);
		burst   = (force_incr || take_bits(1) != 0) ? BURST_INCR : BURST_FIXED;
		run_write(addr, len, burst, pattern);
		run_read(addr, len, burst);
		check_regs();
	endtask

	task automatic reg_access_check();
		logic [DATA_WIDTH-1:0] len_word;
		logic [DATA_WIDTH-1:0] addr_word;
		logic [DATA_WIDTH-1:0] pat_word;
		read_expect(REG_STATUS, '0, "status");
		len_word  = DATA_WIDTH'(LEN_WIDTH'(take_bits(LEN_WIDTH)));
		addr_word = take_bits(DATA_WIDTH);
		pat_word  = take_bits(DATA_WIDTH);
		cpu_write(REG_LENGTH, len_word);
		cpu_write(REG_ADDR, addr_word);
		cpu_write(REG_PATTERN, pat_word);
		// burst bit only, no start
		cpu_write(REG_CTRL, ctrl_word(BURST_INCR, 1'b0, 1'b0));
		read_expect(REG_LENGTH, len_word, "length");
		read_expect(REG_ADDR, addr_word, "addr");
		read_expect(REG_PATTERN, pat_word, "pattern");
		read_expect(REG_CTRL, ctrl_word(BURST_INCR, 1'b0, 1'b0), "ctrl");
		read_expect(REG_STATUS, '0, "status");
	endtask

	task automatic fixed_bursts();
		logic [DATA_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
		addr = take_bits(MEM_AW);
		len  = LEN_WIDTH'(2 + take_bits(4));
		run_write(addr, len, BURST_FIXED, take_bits(DATA_WIDTH));
		run_read(addr, len, BURST_FIXED);
		check_regs();
		addr = take_bits(MEM_AW);
		run_write(addr, '0, BURST_FIXED, take_bits(DATA_WIDTH));
		run_read(addr, '0, BURST_FIXED);
		check_regs();
	endtask

	task automatic wrap_bursts();
		logic [DATA_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wrap;
		logic [DATA_WIDTH-1:0] pattern;
		logic [LEN_WIDTH-1:0]  len;
		addr    = 32'(MEM_SIZE - 1) - take_bits(2);
		len     = LEN_WIDTH'(8 + take_bits(3));
		pattern = take_bits(DATA_WIDTH);
		run_write(addr, len, BURST_INCR, pattern);
		check_regs();
		// last beat landed past the top, folded to a low address
		wrap = addr + DATA_WIDTH'(len);
		// one word just below the burst queues the wrapped word for the checker
		run_write(addr - 1, '0, BURST_INCR, pattern + DATA_WIDTH'(len));
		run_read(wrap, '0, BURST_INCR);
		check_regs();
	endtask

	task automatic busy_start();
		logic [DATA_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] pattern;
		logic [LEN_WIDTH-1:0]  len;
		addr    = take_bits(MEM_AW);
		len     = LEN_WIDTH'(180 + take_bits(6));
		pattern = take_bits(DATA_WIDTH);
		cpu_write(REG_LENGTH, DATA_WIDTH'(len));
		cpu_write(REG_ADDR, addr);
		cpu_write(REG_PATTERN, pattern);
		cpu_write(REG_CTRL, ctrl_word(BURST_INCR, 1'b1, 1'b0));
		wait_status(STS_BUSY, "busy");
		cpu_write(REG_PATTERN, ~pattern);
		cpu_write(REG_CTRL, ctrl_word(BURST_INCR, 1'b1, 1'b1));
		wait_status(STS_WR_DONE, "write done");
		model_write(addr, len, BURST_INCR, pattern);
		repeat (20) @(negedge ms_wr_clk);
		check_regs();
		run_read(addr, len, BURST_INCR);
		check_regs();
	endtask

	initial begin
		int p;
		i_arst_n  = 1'b0;
		i_wr_addr = '0;
		i_wrdata  = '0;
		i_wren    = 1'b0;
		i_rden    = 1'b0;
		repeat (10) @(negedge ms_wr_clk);
		i_arst_n = 1'b1;
		@(negedge ms_wr_clk);

		reg_access_check();
		random_pair(1'b1);
		fixed_bursts();
		wrap_bursts();
		busy_start();
		for (p = 0; p < NUM_PAIRS; p++)
			random_pair(1'b0);

		repeat (4) @(negedge ms_wr_clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- src.f
hdl/axi_burst_pkg.sv
hdl/csr_map_pkg.sv
hdl/aximm_csr.sv
hdl/aximm_leader_app.sv
hdl/aximm_follower_app.sv
hdl/burst_mem.sv
hdl/aximm_patchkr.sv
hdl/aximm_loopback_top.sv
verif/tb_aximm_loopback_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_aximm_loopback_top -o sim_tb
./obj_dir/sim_tb
